//--- micro_cpu_pkg.sv
package micro_cpu_pkg;

    localparam int OPCODE_WIDTH  = 4;   // Upper nibble of an instruction
    localparam int OPERAND_WIDTH = 4;   // Lower nibble, address or immediate
    localparam int ADDR_WIDTH    = 4;   // PC and MAR width
    localparam int RAM_DEPTH     = 16;  // Program and data share one array
    localparam int STEP_COUNT    = 8;   // Microsteps per opcode

    // Instruction set, encoded 0 to 15
    typedef enum logic [OPCODE_WIDTH-1:0] {
        NOP, LDA, LDB, ADD, SUB, AND, OR, STA,
        LDI, JMP, JC, JZ, JN, OUTM, OUTA, HLT
    } opcode_t;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,    // A plus inverted B plus one
        ALU_AND,
        ALU_OR
    } alu_op_t;

    typedef enum logic [$clog2(STEP_COUNT)-1:0] {
        MS0, MS1, MS2, MS3, MS4, MS5, MS6, MS7
    } microstep_t;

    typedef enum logic [2:0] {
        S_RESET,    // One idle cycle after reset
        S_FETCH_0,
        S_FETCH_1,
        S_DECODE_0,
        S_DECODE_1,
        S_WAIT,     // IR settles before the ROM lookup
        S_EXECUTE,
        S_HALT
    } seq_state_t;

    typedef struct packed {
        // Register loads from the bus
        logic    load_o;
        logic    load_a;
        logic    load_b;
        logic    load_ir;
        logic    load_pc;
        logic    load_mar;
        logic    load_ram;
        logic    load_flags;
        logic    load_sets_zn;  // Z and N from the loaded bus value
        // Bus drivers
        logic    oe_a;
        logic    oe_ir;
        logic    oe_pc;
        logic    oe_alu;
        logic    oe_ram;
        logic    pc_enable;     // PC increment
        alu_op_t alu_op;
        // Conditional jump qualifiers
        logic    check_zero;
        logic    check_carry;
        logic    check_negative;
        logic    halt;
        logic    last_step;     // Back to fetch after this step
    } control_word_t;

endpackage

//--- microcode_rom.sv
module microcode_rom (
    input  micro_cpu_pkg::opcode_t       opcode_i,
    input  micro_cpu_pkg::microstep_t    step_i,
    output micro_cpu_pkg::control_word_t word_o
);
    import micro_cpu_pkg::*;

    alu_op_t alu_sel;

    // ALU function of the four arithmetic opcodes
    always_comb begin
        case (opcode_i)
            SUB:     alu_sel = ALU_SUB;
            AND:     alu_sel = ALU_AND;
            OR:      alu_sel = ALU_OR;
            default: alu_sel = ALU_ADD;
        endcase
    end

    always_comb begin
        word_o = '0; // Unused steps stay all zero
        case (opcode_i)
            NOP: word_o.last_step = (step_i == MS0);
            // Memory operand group, address from IR into MAR first
            LDA, LDB, ADD, SUB, AND, OR, STA, OUTM: begin
                case (step_i)
                    MS0: word_o.oe_ir = 1'b1;
                    MS1: begin
                        word_o.oe_ir    = 1'b1;
                        word_o.load_mar = 1'b1;
                    end
                    MS2, MS3: begin
                        word_o.oe_a   = (opcode_i == STA);  // Store puts A on the bus
                        word_o.oe_ram = (opcode_i != STA);
                    end
                    default: ;
                endcase
                if (step_i == MS3) begin
                    word_o.load_a       = (opcode_i == LDA);
                    word_o.load_b       = opcode_i inside {LDB, ADD, SUB, AND, OR};
                    word_o.load_o       = (opcode_i == OUTM);
                    word_o.load_ram     = (opcode_i == STA);
                    word_o.load_flags   = opcode_i inside {LDA, LDB};
                    word_o.load_sets_zn = opcode_i inside {LDA, LDB};
                    word_o.last_step    = opcode_i inside {LDA, LDB, STA, OUTM};
                end
                // ALU steps, op held across both since the result is not latched
                if (opcode_i inside {ADD, SUB, AND, OR} && step_i inside {MS4, MS5}) begin
                    word_o.oe_alu     = 1'b1;
                    word_o.alu_op     = alu_sel;
                    word_o.load_flags = (step_i == MS4);
                    word_o.load_a     = (step_i == MS5);   // A written back last
                    word_o.last_step  = (step_i == MS5);
                end
            end
            // Immediate group, operand straight from IR
            LDI, JMP, JC, JZ, JN: begin
                word_o.oe_ir = step_i inside {MS0, MS1};
                if (step_i == MS1) begin
                    word_o.load_a         = (opcode_i == LDI);
                    word_o.load_flags     = (opcode_i == LDI);
                    word_o.load_sets_zn   = (opcode_i == LDI);
                    word_o.load_pc        = (opcode_i != LDI);
                    word_o.check_carry    = (opcode_i == JC);
                    word_o.check_zero     = (opcode_i == JZ);
                    word_o.check_negative = (opcode_i == JN);
                    word_o.last_step      = 1'b1;
                end
            end
            OUTA: begin
                word_o.oe_a      = step_i inside {MS0, MS1};
                word_o.load_o    = (step_i == MS1);
                word_o.last_step = (step_i == MS1);
            end
            HLT: begin
                word_o.halt      = (step_i == MS1);     // MS0 is a settle cycle
                word_o.last_step = (step_i == MS1);
            end
            default: ;
        endcase
    end

endmodule

//--- control_sequencer.sv
module control_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  micro_cpu_pkg::opcode_t opcode_i,
    input  logic [2:0]             flags_i,     // N, C, Z
    output logic                   load_o_o,
    output logic                   load_a_o,
    output logic                   load_b_o,
    output logic                   load_ir_o,
    output logic                   load_pc_o,
    output logic                   load_mar_o,
    output logic                   load_ram_o,
    output logic                   load_flags_o,
    output logic                   load_sets_zn_o,
    output logic                   oe_a_o,
    output logic                   oe_ir_o,
    output logic                   oe_pc_o,
    output logic                   oe_alu_o,
    output logic                   oe_ram_o,
    output logic                   pc_enable_o,
    output micro_cpu_pkg::alu_op_t alu_op_o,
    output logic                   halted_o
);
    import micro_cpu_pkg::*;

    seq_state_t    state;
    seq_state_t    next_state;
    microstep_t    step;
    microstep_t    next_step;
    control_word_t rom_word;
    control_word_t word;
    logic          check_any;
    logic          check_pass;

    microcode_rom i_microcode_rom (
        .opcode_i (opcode_i),
        .step_i   (step),
        .word_o   (rom_word)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_RESET;
            step  <= MS0;
        end else begin
            state <= next_state;
            step  <= next_step;
        end
    end

    // Jump qualifiers against the registered flags
    assign check_any  = rom_word.check_zero | rom_word.check_carry | rom_word.check_negative;
    assign check_pass = (rom_word.check_zero & flags_i[0]) | (rom_word.check_carry & flags_i[1])
                      | (rom_word.check_negative & flags_i[2]);

    always_comb begin
        word       = '0;
        next_state = state;
        next_step  = step;
        case (state)
            S_RESET:    next_state = S_FETCH_0;
            S_FETCH_0: begin
                word.oe_pc = 1'b1;
                next_state = S_FETCH_1;
            end
            S_FETCH_1: begin
                word.oe_pc    = 1'b1;
                word.load_mar = 1'b1;  // PC into MAR
                next_state    = S_DECODE_0;
            end
            S_DECODE_0: begin
                word.oe_ram = 1'b1;
                next_state  = S_DECODE_1;
            end
            S_DECODE_1: begin
                word.oe_ram    = 1'b1;
                word.load_ir   = 1'b1;
                word.pc_enable = 1'b1;  // Point at next instruction
                next_state     = S_WAIT;
            end
            S_WAIT:     next_state = S_EXECUTE;
            S_EXECUTE: begin
                word = rom_word;
                if (rom_word.halt) begin
                    next_state = S_HALT;
                    next_step  = MS0;
                end else if (check_any && !check_pass) begin
                    word.load_pc = 1'b0;   // Jump not taken
                    next_state   = S_FETCH_0;
                    next_step    = MS0;
                end else if (rom_word.last_step) begin
                    next_state = S_FETCH_0;
                    next_step  = MS0;
                end else begin
                    next_step = microstep_t'(step + 3'd1);
                end
            end
            S_HALT:     next_state = S_HALT; // Only reset leaves
            default:    next_state = S_RESET;
        endcase
    end

    assign load_o_o       = word.load_o;
    assign load_a_o       = word.load_a;
    assign load_b_o       = word.load_b;
    assign load_ir_o      = word.load_ir;
    assign load_pc_o      = word.load_pc;
    assign load_mar_o     = word.load_mar;
    assign load_ram_o     = word.load_ram;
    assign load_flags_o   = word.load_flags;
    assign load_sets_zn_o = word.load_sets_zn;
    assign oe_a_o         = word.oe_a;
    assign oe_ir_o        = word.oe_ir;
    assign oe_pc_o        = word.oe_pc;
    assign oe_alu_o       = word.oe_alu;
    assign oe_ram_o       = word.oe_ram;
    assign pc_enable_o    = word.pc_enable;
    assign alu_op_o       = word.alu_op;
    assign halted_o       = (state == S_HALT); // Rises the cycle after HLT's MS1

endmodule

//--- bus_arbiter.sv
module bus_arbiter #(
    parameter int DATA_WIDTH = 8
) (
    input  logic [micro_cpu_pkg::ADDR_WIDTH-1:0]    pc_i,
    input  logic [DATA_WIDTH-1:0]                   ram_i,
    input  logic [micro_cpu_pkg::OPERAND_WIDTH-1:0] operand_i,
    input  logic [DATA_WIDTH-1:0]                   alu_i,
    input  logic [DATA_WIDTH-1:0]                   a_i,
    input  logic                                    oe_pc_i,
    input  logic                                    oe_ram_i,
    input  logic                                    oe_ir_i,
    input  logic                                    oe_alu_i,
    input  logic                                    oe_a_i,
    output logic [DATA_WIDTH-1:0]                   bus_o
);
    import micro_cpu_pkg::*;

    // Fixed priority mux in place of tri-state drivers
    always_comb begin
        if (oe_pc_i) begin
            bus_o = {{(DATA_WIDTH-ADDR_WIDTH){1'b0}}, pc_i};            // Zero extended
        end else if (oe_ram_i) begin
            bus_o = ram_i;
        end else if (oe_ir_i) begin
            bus_o = {{(DATA_WIDTH-OPERAND_WIDTH){1'b0}}, operand_i};    // Zero extended
        end else if (oe_alu_i) begin
            bus_o = alu_i;
        end else if (oe_a_i) begin
            bus_o = a_i;
        end else begin
            bus_o = '0; // Idle bus reads zero
        end
    end

endmodule

//--- cpu_registers.sv
module cpu_registers #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [DATA_WIDTH-1:0]                   bus_i,
    input  logic                                    load_a_i,
    input  logic                                    load_b_i,
    input  logic                                    load_o_i,
    input  logic                                    load_ir_i,
    input  logic                                    load_mar_i,
    input  logic                                    load_pc_i,
    input  logic                                    pc_enable_i,
    output logic [DATA_WIDTH-1:0]                   a_o,
    output logic [DATA_WIDTH-1:0]                   b_o,
    output logic [DATA_WIDTH-1:0]                   out_o,
    output logic                                    out_strobe_o,
    output micro_cpu_pkg::opcode_t                  opcode_o,
    output logic [micro_cpu_pkg::OPERAND_WIDTH-1:0] operand_o,
    output logic [micro_cpu_pkg::ADDR_WIDTH-1:0]    mar_o,
    output logic [micro_cpu_pkg::ADDR_WIDTH-1:0]    pc_o
);
    import micro_cpu_pkg::*;

    localparam int IR_WIDTH = OPCODE_WIDTH + OPERAND_WIDTH;

    logic [IR_WIDTH-1:0] ir;

    always_ff @(posedge clk) begin
        if (reset) begin
            a_o          <= '0;
            b_o          <= '0;
            out_o        <= '0;
            out_strobe_o <= 1'b0;
            ir           <= '0;
            mar_o        <= '0;
            pc_o         <= '0;
        end else begin
            out_strobe_o <= load_o_i;   // Marks the edge O takes its value
            if (load_a_i) a_o <= bus_i;
            if (load_b_i) b_o <= bus_i;
            if (load_o_i) out_o <= bus_i;
            if (load_ir_i) ir <= bus_i[IR_WIDTH-1:0];
            if (load_mar_i) mar_o <= bus_i[ADDR_WIDTH-1:0];
            // Jump target wins over increment
            if (load_pc_i) begin
                pc_o <= bus_i[ADDR_WIDTH-1:0];
            end else if (pc_enable_i) begin
                pc_o <= pc_o + 1'b1;    // Wraps at 16
            end
        end
    end

    assign opcode_o  = opcode_t'(ir[OPERAND_WIDTH +: OPCODE_WIDTH]); // High nibble
    assign operand_o = ir[OPERAND_WIDTH-1:0];

endmodule

//--- alu_flags.sv
module alu_flags #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [DATA_WIDTH-1:0]  a_i,
    input  logic [DATA_WIDTH-1:0]  b_i,
    input  logic [DATA_WIDTH-1:0]  bus_i,
    input  micro_cpu_pkg::alu_op_t alu_op_i,
    input  logic                   load_flags_i,
    input  logic                   load_sets_zn_i,
    output logic [DATA_WIDTH-1:0]  result_o,
    output logic [2:0]             flags_o      // N, C, Z
);
    import micro_cpu_pkg::*;

    logic                  subtract;
    logic [DATA_WIDTH-1:0] b_term;
    logic [DATA_WIDTH:0]   sum;
    logic                  carry;

    // Shared adder, subtract as two's complement
    assign subtract = (alu_op_i == ALU_SUB);
    assign b_term   = subtract ? ~b_i : b_i;
    assign sum      = {1'b0, a_i} + {1'b0, b_term} + {{DATA_WIDTH{1'b0}}, subtract};

    always_comb begin
        case (alu_op_i)
            ALU_AND: begin
                result_o = a_i & b_i;
                carry    = 1'b0;
            end
            ALU_OR: begin
                result_o = a_i | b_i;
                carry    = 1'b0;
            end
            default: begin
                result_o = sum[DATA_WIDTH-1:0];
                carry    = sum[DATA_WIDTH];     // Set on SUB when A >= B
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flags_o <= '0;
        end else if (load_flags_i) begin
            if (load_sets_zn_i) begin
                flags_o <= {bus_i[DATA_WIDTH-1], flags_o[1], bus_i == '0};  // Carry kept
            end else begin
                flags_o <= {result_o[DATA_WIDTH-1], carry, result_o == '0};
            end
        end
    end

endmodule

//--- program_ram.sv
module program_ram #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 we_i,
    input  logic [micro_cpu_pkg::ADDR_WIDTH-1:0] addr_i,
    input  logic [DATA_WIDTH-1:0]                data_i,
    input  logic                                 prog_we_i,
    input  logic [micro_cpu_pkg::ADDR_WIDTH-1:0] prog_addr_i,
    input  logic [DATA_WIDTH-1:0]                prog_data_i,
    output logic [DATA_WIDTH-1:0]                data_o
);
    import micro_cpu_pkg::*;

    logic [DATA_WIDTH-1:0] mem [RAM_DEPTH];
    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [DATA_WIDTH-1:0] wr_data;

    // Loader owns the write port while reset is held
    assign wr_en   = reset ? prog_we_i : we_i;
    assign wr_addr = reset ? prog_addr_i : addr_i;
    assign wr_data = reset ? prog_data_i : data_i;

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= wr_data;
    end

    assign data_o = mem[addr_i]; // Asynchronous read at MAR

endmodule

//--- micro_cpu.sv
module micro_cpu #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 prog_we_i,
    input  logic [micro_cpu_pkg::ADDR_WIDTH-1:0] prog_addr_i,
    input  logic [DATA_WIDTH-1:0]                prog_data_i,
    output logic [DATA_WIDTH-1:0]                out_o,
    output logic                                 out_strobe_o,
    output logic                                 flag_zero_o,
    output logic                                 flag_carry_o,
    output logic                                 flag_negative_o,
    output logic                                 halted_o
);
    import micro_cpu_pkg::*;

    logic [DATA_WIDTH-1:0]    bus;
    logic [DATA_WIDTH-1:0]    a_val;
    logic [DATA_WIDTH-1:0]    b_val;
    logic [DATA_WIDTH-1:0]    alu_result;
    logic [DATA_WIDTH-1:0]    ram_data;
    logic [ADDR_WIDTH-1:0]    pc;
    logic [ADDR_WIDTH-1:0]    mar;
    logic [OPERAND_WIDTH-1:0] operand;
    opcode_t                  opcode;
    alu_op_t                  alu_op;
    logic [2:0]               flags;    // N, C, Z
    logic load_o, load_a, load_b, load_ir, load_pc, load_mar, load_ram;
    logic load_flags, load_sets_zn, pc_enable;
    logic oe_a, oe_ir, oe_pc, oe_alu, oe_ram;

    control_sequencer i_control_sequencer (
        .clk(clk), .reset(reset), .opcode_i(opcode), .flags_i(flags),
        .load_o_o(load_o), .load_a_o(load_a), .load_b_o(load_b),
        .load_ir_o(load_ir), .load_pc_o(load_pc), .load_mar_o(load_mar),
        .load_ram_o(load_ram), .load_flags_o(load_flags), .load_sets_zn_o(load_sets_zn),
        .oe_a_o(oe_a), .oe_ir_o(oe_ir), .oe_pc_o(oe_pc), .oe_alu_o(oe_alu),
        .oe_ram_o(oe_ram), .pc_enable_o(pc_enable), .alu_op_o(alu_op),
        .halted_o(halted_o)
    );

    // Single bus, one driver at a time
    bus_arbiter #(.DATA_WIDTH(DATA_WIDTH)) i_bus_arbiter (
        .pc_i(pc), .ram_i(ram_data), .operand_i(operand), .alu_i(alu_result), .a_i(a_val),
        .oe_pc_i(oe_pc), .oe_ram_i(oe_ram), .oe_ir_i(oe_ir), .oe_alu_i(oe_alu),
        .oe_a_i(oe_a), .bus_o(bus)
    );

    cpu_registers #(.DATA_WIDTH(DATA_WIDTH)) i_cpu_registers (
        .clk(clk), .reset(reset), .bus_i(bus),
        .load_a_i(load_a), .load_b_i(load_b), .load_o_i(load_o), .load_ir_i(load_ir),
        .load_mar_i(load_mar), .load_pc_i(load_pc), .pc_enable_i(pc_enable),
        .a_o(a_val), .b_o(b_val), .out_o(out_o), .out_strobe_o(out_strobe_o),
        .opcode_o(opcode), .operand_o(operand), .mar_o(mar), .pc_o(pc)
    );

    alu_flags #(.DATA_WIDTH(DATA_WIDTH)) i_alu_flags (
        .clk(clk), .reset(reset), .a_i(a_val), .b_i(b_val), .bus_i(bus),
        .alu_op_i(alu_op), .load_flags_i(load_flags), .load_sets_zn_i(load_sets_zn),
        .result_o(alu_result), .flags_o(flags)
    );

    // Program and data memory, filled by the loader during reset
    program_ram #(.DATA_WIDTH(DATA_WIDTH)) i_program_ram (
        .clk(clk), .reset(reset), .we_i(load_ram), .addr_i(mar), .data_i(bus),
        .prog_we_i(prog_we_i), .prog_addr_i(prog_addr_i), .prog_data_i(prog_data_i),
        .data_o(ram_data)
    );

    assign flag_zero_o     = flags[0];
    assign flag_carry_o    = flags[1];
    assign flag_negative_o = flags[2];

endmodule

//--- micro_cpu_tb.sv
module micro_cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import micro_cpu_pkg::*;

    localparam int DATA_WIDTH   = 8;
    localparam int CLK_PERIOD   = 20;
    localparam int LOAD_CYCLES  = (RAM_DEPTH > 10) ? RAM_DEPTH : 10;   // Reset high 10 cycles or more
    localparam int MAX_TESTS    = 16;
    localparam int MAX_OUTS     = 16;
    localparam int HALT_LIMIT   = 2000;    // Cycles allowed before halted_o
    localparam int QUIET_CYCLES = 50;

    logic                  clk;
    logic                  reset;
    logic                  prog_we_i;
    logic [ADDR_WIDTH-1:0] prog_addr_i;
    logic [DATA_WIDTH-1:0] prog_data_i;
    logic [DATA_WIDTH-1:0] out_o;
    logic                  out_strobe_o;
    logic [2:0]            flags;      // N, C, Z
    logic                  halted_o;
    string                 names [MAX_TESTS];
    int                    cut_cycles [MAX_TESTS];    // Nonzero means reset mid-run
    int                    exp_count [MAX_TESTS];
    logic [DATA_WIDTH-1:0] programs [MAX_TESTS][RAM_DEPTH];
    logic [DATA_WIDTH-1:0] expected [MAX_TESTS][MAX_OUTS];
    logic [2:0]            exp_flags [MAX_TESTS];
    logic [DATA_WIDTH-1:0] observed [$];
    int                    num_tests;
    int                    error_count;
    bit                    vectors_ready;
    int                    seed = 32'h7dd4_e359;    // For randomized stimulus

    micro_cpu #(.DATA_WIDTH(DATA_WIDTH)) i_dut (
        .clk(clk), .reset(reset), .prog_we_i(prog_we_i), .prog_addr_i(prog_addr_i),
        .prog_data_i(prog_data_i), .out_o(out_o), .out_strobe_o(out_strobe_o),
        .flag_zero_o(flags[0]), .flag_carry_o(flags[1]), .flag_negative_o(flags[2]),
        .halted_o(halted_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // O already holds the new value while the strobe is high
    always @(negedge clk) begin
        if (!reset && out_strobe_o) observed.push_back(out_o);
    end

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (exp_val !== act_val) begin
            error_count++;
            $display("error %s expected %0h actual %0h", name, exp_val, act_val);
        end
    endtask

    task automatic report_problem(input string msg);
        error_count++;
        $display("%s", msg);
    endtask

    task automatic read_vectors();
        int                    fd;
        int                    fields;
        int                    value;
        int                    i;
        string                 token;
        string                 line;
        logic [DATA_WIDTH-1:0] byte_val;
        logic                  z_bit;
        logic                  c_bit;
        logic                  n_bit;
        fd = $fopen("micro_cpu_vectors.txt", "r");
        if (fd == 0) begin
            report_problem("cannot open micro_cpu_vectors.txt");
        end else begin
            while ($fscanf(fd, "%s", token) == 1 && num_tests < MAX_TESTS) begin
                if (token.substr(0, 0) == "#") begin
                    value = $fgets(line, fd);  // Rest of a comment line
                end else begin
                    fields = $fscanf(fd, "%d", value);
                    cut_cycles[num_tests] = value;
                    for (i = 0; i < RAM_DEPTH; i++) begin
                        fields += $fscanf(fd, "%h", byte_val);
                        programs[num_tests][i] = byte_val;
                    end
                    fields += $fscanf(fd, "%d", value);
                    exp_count[num_tests] = (value < MAX_OUTS) ? value : MAX_OUTS;
                    for (i = 0; i < exp_count[num_tests]; i++) begin
                        fields += $fscanf(fd, "%h", byte_val);
                        expected[num_tests][i] = byte_val;
                    end
                    fields += $fscanf(fd, "%b %b %b", z_bit, c_bit, n_bit);
                    exp_flags[num_tests] = {n_bit, c_bit, z_bit};
                    if (fields != RAM_DEPTH + exp_count[num_tests] + 5)
                        report_problem({"incomplete vector record for ", token});
                    names[num_tests] = token;
                    num_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Loader writes one byte per cycle while reset is held
    task automatic load_program(input int t);
        int i;
        for (i = 0; i < LOAD_CYCLES; i++) begin
            @(posedge clk);
            reset       <= 1'b1;
            prog_we_i   <= (i < RAM_DEPTH);
            prog_addr_i <= ADDR_WIDTH'(i % RAM_DEPTH);
            prog_data_i <= programs[t][i % RAM_DEPTH];
        end
        observed.delete();
        @(posedge clk);
        reset     <= 1'b0;
        prog_we_i <= 1'b0;
    endtask

    task automatic run_test(input int t);
        int cycles;
        int dropped;
        int at_halt;
        int n;
        int i;
        load_program(t);
        @(negedge clk);
        check_value({names[t], " out after reset"}, 32'd0, 32'(out_o));
        check_value({names[t], " flags after reset"}, 32'd0, 32'(flags));
        cycles  = 0;
        dropped = 0;
        if (cut_cycles[t] > 0) begin
            repeat (cut_cycles[t]) @(negedge clk);   // Next load resets mid-run
            if (observed.size() == 0)
                report_problem({names[t], ": no output before the mid-run reset"});
        end else begin
            while (halted_o == 1'b0 && cycles < HALT_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (halted_o == 1'b0) begin
                report_problem({names[t], ": program never raised halted_o"});
            end else begin
                at_halt = observed.size();
                repeat (QUIET_CYCLES) begin
                    @(negedge clk);
                    if (halted_o == 1'b0) dropped++;
                end
                if (dropped > 0) report_problem({names[t], ": halted_o fell after halt"});
                if (observed.size() != at_halt)
                    report_problem({names[t], ": output strobe after halt"});
                check_value({names[t], " flags NCZ"}, 32'(exp_flags[t]), 32'(flags));
            end
        end
        if (observed.size() > exp_count[t])
            report_problem({names[t], ": too many output strobes"});
        else if (cut_cycles[t] == 0)
            check_value({names[t], " output count"}, exp_count[t], observed.size());
        n = (observed.size() < exp_count[t]) ? observed.size() : exp_count[t];
        for (i = 0; i < n; i++) begin
            check_value($sformatf("%s out %0d", names[t], i), 32'(expected[t][i]),
                        32'(observed[i]));
        end
    endtask

    initial begin
        int t;
        reset       = 1'b1;
        prog_we_i   = 1'b0;
        prog_addr_i = '0;
        prog_data_i = '0;
        read_vectors();
        if (num_tests == 0) report_problem("no test vectors were read");
        vectors_ready = 1'b1;
        for (t = 0; t < num_tests; t++) run_test(t);
        $display("tests %0d errors %0d", num_tests, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // 300 instructions of at most 11 cycles per test
    initial begin
        wait (vectors_ready);
        #((num_tests > 0 ? num_tests : 1) * 300 * 11 * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- micro_cpu_vectors.txt
# name, cut cycles (0 runs to halt), then the 16 program bytes in hex
# output count and expected outputs in hex, then final flags Z C N
load_out 0
85 E0 1E E0 DF DE F0 00 00 00 00 00 00 00 9C 3A
4 05 9C 3A 9C   0 0 1
alu 0
1D 3E E0 4F E0 5C E0 6C E0 4C E0 F0 0F C8 64 10
5 2C 1C 0C 0F 00   1 1 0
store 0
87 3F 7E 8F DE 1E E0 4D E0 7C DC F0 00 30 00 20
4 27 27 F7 F7   0 0 1
jumps 0
83 E0 4F B5 91 C0 A8 E0 4F CB E0 A0 B0 E0 F0 01
4 03 02 01 FF   0 0 1
abort 150
4F E0 90 00 00 00 00 00 00 00 00 00 00 00 00 01
8 FF FE FD FC FB FA F9 F8   0 0 0
reload 0
E0 C0 8A E0 A0 3F E0 F0 00 00 00 00 00 00 00 F6
3 00 0A 00   1 1 0

//--- micro_cpu.f
micro_cpu_pkg.sv
microcode_rom.sv
control_sequencer.sv
bus_arbiter.sv
cpu_registers.sv
alu_flags.sv
program_ram.sv
micro_cpu.sv
micro_cpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the micro_cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps --top-module micro_cpu_tb \
        -Mdir obj_dir -f micro_cpu.f; then
    echo "Verilator build failed"
    exit 1
fi

sim_output="$(./obj_dir/Vmicro_cpu_tb)"
sim_status=$?
echo "$sim_output"
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
